/* all.f */
hdl/axi_read_pkg.sv
hdl/read_engine_pkg.sv
hdl/burst_planner.sv
hdl/ar_issuer.sv
hdl/read_data_fifo.sv
hdl/read_completion.sv
hdl/axi_read_engine.sv
tests/tb_axi_read_engine_assertions.sv
tests/tb_axi_read_engine.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run, the exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f \
  --top-module tb_axi_read_engine -o tb_axi_read_engine &&
./obj_dir/tb_axi_read_engine || exit 1

/* tests/tb_axi_read_engine.sv */
////////////////////////////////////////
// testbench for the burst read engine
// runs five transfers against an AXI slave memory model with random gaps
// and checks every address request, every streamed word and every done pulse
////////////////////////////////////////

`timescale 1ns/1ps

module tb_axi_read_engine;

  // beats over all runs, the watchdog limit grows with them
  localparam int TOTAL_BEATS = 5 + 48 + 150 + 40 + 20;
  localparam int TIMEOUT_CYCLES = 200 * TOTAL_BEATS + 1000;

  logic                       aclk;
  logic                       areset;
  logic                       ctrl_start;
  read_engine_pkg::read_req_t ctrl_req;
  logic                       ctrl_busy;
  logic                       ctrl_done;
  logic                       arvalid;
  logic                       arready;
  axi_read_pkg::ar_req_t      ar;
  logic                       rvalid;
  logic                       rready;
  axi_read_pkg::r_beat_t      r;
  logic                       m_tvalid;
  logic                       m_tready;
  axi_read_pkg::data_t        m_tdata;

  // expected requests, and requests the slave still has to answer
  axi_read_pkg::ar_req_t exp_ar_q[$];
  axi_read_pkg::ar_req_t slave_q[$];

  // run bookkeeping written by the stimulus, totals written by the monitors
  logic [31:0] run_offset;
  int          run_length;
  int          run_bursts;
  int          run_word_base;
  int          run_done_base;
  int          run_rlast_base;
  bit          tready_random;
  int          words_total = 0;
  int          done_total = 0;
  int          rlast_total = 0;
  bit          rlast_prev = 1'b0;

  axi_read_engine i_axi_read_engine (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_req   (ctrl_req),
    .ctrl_busy  (ctrl_busy),
    .ctrl_done  (ctrl_done),
    .arvalid    (arvalid),
    .arready    (arready),
    .ar         (ar),
    .rvalid     (rvalid),
    .rready     (rready),
    .r          (r),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  ////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////

  // memory contents, every address bit changes the word
  function automatic axi_read_pkg::data_t mem_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f1e;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  // full 16-beat bursts 64 bytes apart, then one shorter tail if any beats remain
  task automatic expect_bursts(input logic [31:0] offset, input int length);
    axi_read_pkg::ar_req_t req;
    int                    remaining;
    logic [31:0]           addr;
    remaining = length;
    addr = offset;
    while (remaining > 0) begin
      req.addr = addr;
      req.len  = (remaining >= 16) ? 8'd15 : 8'(remaining - 1);
      req.size = 3'd2;
      exp_ar_q.push_back(req);
      remaining = remaining - 16;
      addr = addr + 32'd64;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: time %0t, %s expected %b got %b", $time, name, exp, got));
    end
  endtask

  task automatic check_data(input axi_read_pkg::data_t got, input axi_read_pkg::data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: time %0t, m_tdata expected %h got %h", $time, exp, got));
    end
  endtask

  task automatic check_ar(input axi_read_pkg::ar_req_t got, input axi_read_pkg::ar_req_t exp);
    if (got !== exp) begin
      fail_run($sformatf(
        "Error: time %0t, ar expected addr %h len %h size %h got addr %h len %h size %h",
        $time, exp.addr, exp.len, exp.size, got.addr, got.len, got.size));
    end
  endtask

  // each run must end with exactly one done pulse
  task automatic check_done(input int got);
    if (got != 1) begin
      fail_run($sformatf("Error: time %0t, ctrl_done pulses expected 1 got %0d", $time, got));
    end
  endtask

  ////////////////////////////////////////
  // monitors, sampled on the rising edge
  ////////////////////////////////////////

  always @(posedge aclk) begin
    if (!areset && arvalid && arready) begin
      if (exp_ar_q.size() == 0) begin
        fail_run("an address request was issued that no transfer asked for");
      end else begin
        check_ar(ar, exp_ar_q.pop_front());
        slave_q.push_back(ar);
      end
    end
  end

  // word n of a run comes from the offset plus 4 times n
  always @(posedge aclk) begin
    if (!areset && m_tvalid && m_tready) begin
      if (words_total - run_word_base >= run_length) begin
        fail_run("the stream delivered more words than the transfer asked for");
      end else begin
        check_data(m_tdata, mem_word(run_offset + 32'(4 * (words_total - run_word_base))));
        words_total = words_total + 1;
      end
    end
  end

  // ctrl_done comes one cycle after the rlast handshake of the final burst
  // every offered beat must be taken, so rready stays high
  always @(posedge aclk) begin
    if (!areset && ctrl_done) begin
      done_total = done_total + 1;
      if (ctrl_busy) begin
        fail_run("ctrl_busy was still high in the cycle of ctrl_done");
      end else if (!rlast_prev || (rlast_total - run_rlast_base != run_bursts)) begin
        fail_run("ctrl_done did not come one cycle after the final rlast handshake");
      end
    end
    if (!areset && rvalid) begin
      check_level("rready", rready, 1'b1);
    end
    rlast_prev = !areset && rvalid && rready && r.last;
    if (rlast_prev) begin
      rlast_total = rlast_total + 1;
    end
  end

  ////////////////////////////////////////
  // AXI slave memory model and stream sink
  ////////////////////////////////////////

  // answers queued requests in order, a beat shown at one falling edge
  // is taken at the next rising edge because rready stays high
  initial begin
    axi_read_pkg::ar_req_t cur;
    int                    beat;
    bit                    r_active;
    void'($urandom(32'h69cd4fb5));
    arready = 1'b0;
    rvalid = 1'b0;
    r = '0;
    m_tready = 1'b0;
    beat = 0;
    r_active = 1'b0;
    forever begin
      @(negedge aclk);
      if (!areset) begin
        arready = (($urandom % 4) != 0);
        m_tready = tready_random ? (($urandom % 3) != 0) : 1'b1;
        if (rvalid && rready) begin
          if (r.last) begin
            r_active = 1'b0;
          end else begin
            beat = beat + 1;
          end
        end
        if (!r_active && slave_q.size() > 0) begin
          cur = slave_q.pop_front();
          beat = 0;
          r_active = 1'b1;
        end
        if (r_active && (($urandom % 4) != 0)) begin
          rvalid = 1'b1;
          r.data = mem_word(cur.addr + 32'(4 * beat));
          r.last = (beat == int'(cur.len));
        end else begin
          rvalid = 1'b0;
          r = '0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // start one transfer and wait for its done pulse and its last word
  // with start_again set, a second start arrives while the engine is busy
  task automatic run_transfer(input logic [31:0] offset, input int length,
                              input bit start_again);
    read_engine_pkg::read_req_t req;
    expect_bursts(offset, length);
    run_offset = offset;
    run_length = length;
    run_bursts = (length + 15) / 16;
    run_word_base = words_total;
    run_done_base = done_total;
    run_rlast_base = rlast_total;
    req.offset = offset;
    req.length = 16'(length);
    @(negedge aclk);
    ctrl_start = 1'b1;
    ctrl_req = req;
    @(negedge aclk);
    ctrl_start = 1'b0;
    if (start_again) begin
      @(negedge aclk);
      check_level("ctrl_busy", ctrl_busy, 1'b1);
      ctrl_start = 1'b1;
      ctrl_req.offset = 32'h0000_8000;
      ctrl_req.length = 16'd7;
      @(negedge aclk);
      ctrl_start = 1'b0;
    end
    wait (done_total != run_done_base);
    wait (words_total - run_word_base == run_length);
    repeat (8) @(negedge aclk);
    check_done(done_total - run_done_base);
    if (exp_ar_q.size() != 0) begin
      fail_run("the transfer ended before every expected address request was issued");
    end
  endtask

  initial begin
    areset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_req = '0;
    tready_random = 1'b0;
    run_offset = '0;
    run_length = 0;
    run_bursts = 0;
    run_word_base = 0;
    run_done_base = 0;
    run_rlast_base = 0;
    repeat (5) @(negedge aclk);
    areset = 1'b0;
    // rready comes up one clock after reset
    @(negedge aclk);
    check_level("arvalid", arvalid, 1'b0);
    check_level("m_tvalid", m_tvalid, 1'b0);
    check_level("ctrl_busy", ctrl_busy, 1'b0);
    check_level("ctrl_done", ctrl_done, 1'b0);
    check_level("rready", rready, 1'b1);
    run_transfer(32'h0000_1000, 5, 1'b0);
    run_transfer(32'h0000_2040, 48, 1'b0);
    // long run with a stalling stream sink
    tready_random = 1'b1;
    run_transfer(32'h0001_0000, 150, 1'b0);
    tready_random = 1'b0;
    run_transfer(32'h0003_0100, 40, 1'b1);
    run_transfer(32'h0004_0c00, 20, 1'b0);
    $display("*** TEST PASSED ***");
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge aclk);
    fail_run("timeout, the transfers did not finish in time");
  end

endmodule

/* tests/tb_axi_read_engine_assertions.sv */
////////////////////////////////////////
// concurrent assertions bound into the address issuer
// covers the AXI hold rule and the outstanding-burst credits
////////////////////////////////////////

`timescale 1ns/1ps

module tb_axi_read_engine_assertions (
  input logic                                     aclk,
  input logic                                     areset,
  input logic                                     arvalid,
  input logic                                     arready,
  input axi_read_pkg::ar_req_t                    ar,
  input logic [read_engine_pkg::CREDIT_WIDTH-1:0] credits,
  input logic                                     burst_returned
);

  localparam logic [read_engine_pkg::CREDIT_WIDTH-1:0] FULL_CREDITS =
    read_engine_pkg::MAX_OUTSTANDING[read_engine_pkg::CREDIT_WIDTH-1:0];

  // once raised, arvalid stays up until the slave takes the request
  a_arvalid_hold: assert property (@(posedge aclk) disable iff (areset)
    (arvalid && !arready) |=> arvalid)
    else $error("arvalid dropped before arready");

  a_ar_stable: assert property (@(posedge aclk) disable iff (areset)
    (arvalid && !arready) |=> $stable(ar))
    else $error("ar changed while waiting for arready");

  // a handshake with no credit left would be a fourth outstanding burst
  a_credit_floor: assert property (@(posedge aclk) disable iff (areset)
    (arvalid && arready) |-> (credits != '0))
    else $error("address handshake with no credit left");

  // a returned burst must match one that was issued
  a_credit_ceiling: assert property (@(posedge aclk) disable iff (areset)
    (burst_returned && !(arvalid && arready)) |-> (credits != FULL_CREDITS))
    else $error("burst returned while no burst was outstanding");

endmodule

bind ar_issuer tb_axi_read_engine_assertions i_assertions (
  .aclk           (aclk),
  .areset         (areset),
  .arvalid        (arvalid),
  .arready        (arready),
  .ar             (ar),
  .credits        (credits),
  .burst_returned (burst_returned)
);

/* hdl/axi_read_engine.sv */
////////////////////////////////////////
// burst read engine top level
// fetches a block of words over AXI4 read and streams them out in order
////////////////////////////////////////

`timescale 1ns/1ps

module axi_read_engine (
  input  logic                       aclk,
  input  logic                       areset,
  // control
  input  logic                       ctrl_start,
  input  read_engine_pkg::read_req_t ctrl_req,
  output logic                       ctrl_busy,
  output logic                       ctrl_done,
  // AXI read-address channel
  output logic                       arvalid,
  input  logic                       arready,
  output axi_read_pkg::ar_req_t      ar,
  // AXI read-data channel
  input  logic                       rvalid,
  output logic                       rready,
  input  axi_read_pkg::r_beat_t      r,
  // output stream
  output logic                       m_tvalid,
  input  logic                       m_tready,
  output axi_read_pkg::data_t        m_tdata
);

  logic                         plan_load;
  read_engine_pkg::burst_plan_t plan;
  logic                         fifo_stall;
  logic                         burst_returned;

  burst_planner i_burst_planner (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_req   (ctrl_req),
    .ctrl_done  (ctrl_done),
    .ctrl_busy  (ctrl_busy),
    .plan_load  (plan_load),
    .plan       (plan)
  );

  ar_issuer i_ar_issuer (
    .aclk           (aclk),
    .areset         (areset),
    .plan_load      (plan_load),
    .plan           (plan),
    .fifo_stall     (fifo_stall),
    .burst_returned (burst_returned),
    .arready        (arready),
    .arvalid        (arvalid),
    .ar             (ar)
  );

  read_data_fifo i_read_data_fifo (
    .aclk       (aclk),
    .areset     (areset),
    .rvalid     (rvalid),
    .r          (r),
    .m_tready   (m_tready),
    .rready     (rready),
    .m_tvalid   (m_tvalid),
    .m_tdata    (m_tdata),
    .fifo_stall (fifo_stall)
  );

  read_completion i_read_completion (
    .aclk           (aclk),
    .areset         (areset),
    .plan_load      (plan_load),
    .plan           (plan),
    .rvalid         (rvalid),
    .rready         (rready),
    .r              (r),
    .burst_returned (burst_returned),
    .ctrl_done      (ctrl_done)
  );

endmodule

/* hdl/read_completion.sv */
////////////////////////////////////////
// tracks returned bursts on the R channel
// each rlast gives back a credit, the final one ends the run
////////////////////////////////////////

`timescale 1ns/1ps

module read_completion (
  input  logic                         aclk,
  input  logic                         areset,
  input  logic                         plan_load,
  input  read_engine_pkg::burst_plan_t plan,
  input  logic                         rvalid,
  input  logic                         rready,
  input  axi_read_pkg::r_beat_t        r,
  output logic                         burst_returned,
  output logic                         ctrl_done
);

  logic [read_engine_pkg::BURST_CNT_WIDTH-1:0] bursts_to_return;
  logic                                        active;
  logic                                        final_burst;

  // a burst is back when its last beat is accepted
  assign burst_returned = rvalid & rready & r.last;
  assign final_burst    = active & burst_returned & (bursts_to_return == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_to_return <= '0;
      active           <= 1'b0;
      ctrl_done        <= 1'b0;
    end else begin
      ctrl_done <= final_burst;
      if (plan_load) begin
        bursts_to_return <= plan.bursts_minus_one;
        active           <= 1'b1;
      end else if (final_burst) begin
        active <= 1'b0;
      end else if (burst_returned) begin
        bursts_to_return <= bursts_to_return - 1;
      end
    end
  end

endmodule

/* hdl/read_data_fifo.sv */
////////////////////////////////////////
// first-word-fall-through FIFO between the R channel and the output stream
// rready stays high, the issuer keeps the FIFO from overflowing
////////////////////////////////////////

`timescale 1ns/1ps

module read_data_fifo (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  rvalid,
  input  axi_read_pkg::r_beat_t r,
  input  logic                  m_tready,
  output logic                  rready,
  output logic                  m_tvalid,
  output axi_read_pkg::data_t   m_tdata,
  output logic                  fifo_stall
);

  axi_read_pkg::data_t                         mem [read_engine_pkg::FIFO_DEPTH];
  logic [read_engine_pkg::FIFO_ADDR_WIDTH-1:0] wr_ptr;
  logic [read_engine_pkg::FIFO_ADDR_WIDTH-1:0] rd_ptr;
  logic [read_engine_pkg::FIFO_ADDR_WIDTH:0]   count;
  logic                                        wr_en;
  logic                                        rd_en;

  assign wr_en = rvalid & rready;
  assign rd_en = m_tvalid & m_tready;

  // head word is visible as soon as the count is non-zero
  assign m_tvalid = (count != '0);
  assign m_tdata  = mem[rd_ptr];

  // stop new bursts once a full burst of words is waiting
  assign fifo_stall = (count >= read_engine_pkg::FIFO_STALL_LEVEL);

  // rready comes up with the first clock out of reset and then stays high
  always_ff @(posedge aclk) begin
    if (areset) begin
      rready <= 1'b0;
    end else begin
      rready <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= r.data;
    end
  end

  ////////////////////////////////////////
  // pointers and fill level
  ////////////////////////////////////////

  // depth is a power of two, so the pointers wrap on their own
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1;
        2'b01:   count <= count - 1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hdl/ar_issuer.sv */
////////////////////////////////////////
// issues the bursts of a plan on the AXI read-address channel
// holds back while no credit is left or the data FIFO is filling up
////////////////////////////////////////

`timescale 1ns/1ps

module ar_issuer (
  input  logic                         aclk,
  input  logic                         areset,
  input  logic                         plan_load,
  input  read_engine_pkg::burst_plan_t plan,
  input  logic                         fifo_stall,
  input  logic                         burst_returned,
  input  logic                         arready,
  output logic                         arvalid,
  output axi_read_pkg::ar_req_t        ar
);

  read_engine_pkg::ar_state_t                  state;
  logic [axi_read_pkg::AXI_ADDR_WIDTH-1:0]     addr;
  logic [read_engine_pkg::BURST_CNT_WIDTH-1:0] bursts_to_go;
  logic [read_engine_pkg::CREDIT_WIDTH-1:0]    credits;
  logic                                        ar_hs;
  logic                                        last_burst;

  assign arvalid    = (state == read_engine_pkg::ar_valid);
  assign ar_hs      = arvalid & arready;
  assign last_burst = (bursts_to_go == '0);

  // the plan is held by the planner for the whole run, so final_len is read live
  assign ar.addr = addr;
  assign ar.len  = last_burst ? plan.final_len : read_engine_pkg::FULL_LEN;
  assign ar.size = axi_read_pkg::AXI_SIZE;

  ////////////////////////////////////////
  // address-channel FSM
  ////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= read_engine_pkg::ar_idle;
    end else begin
      case (state)
        read_engine_pkg::ar_idle: begin
          if (plan_load) begin
            state <= read_engine_pkg::ar_wait;
          end
        end
        // a new burst needs a free credit and room in the FIFO
        read_engine_pkg::ar_wait: begin
          if ((credits != '0) && !fifo_stall) begin
            state <= read_engine_pkg::ar_valid;
          end
        end
        // arvalid and ar hold here until the slave takes them
        read_engine_pkg::ar_valid: begin
          if (arready) begin
            state <= last_burst ? read_engine_pkg::ar_idle : read_engine_pkg::ar_wait;
          end
        end
        default: begin
          state <= read_engine_pkg::ar_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // address and burst counting
  ////////////////////////////////////////

  // address steps one full burst per handshake, only the last burst may be short
  always_ff @(posedge aclk) begin
    if (plan_load) begin
      addr <= plan.offset;
    end else if (ar_hs) begin
      addr <= addr + axi_read_pkg::BURST_BYTES;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_to_go <= '0;
    end else if (plan_load) begin
      bursts_to_go <= plan.bursts_minus_one;
    end else if (ar_hs && !last_burst) begin
      bursts_to_go <= bursts_to_go - 1;
    end
  end

  // one credit per outstanding burst
  // a handshake and a returned burst in the same cycle cancel out
  always_ff @(posedge aclk) begin
    if (areset) begin
      credits <= read_engine_pkg::MAX_OUTSTANDING[read_engine_pkg::CREDIT_WIDTH-1:0];
    end else begin
      case ({ar_hs, burst_returned})
        2'b10:   credits <= credits - 1;
        2'b01:   credits <= credits + 1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

/* hdl/burst_planner.sv */
////////////////////////////////////////
// takes a start pulse and a request, and turns the length into a burst plan
// plan stays stable for the whole run, busy drops with the done pulse
////////////////////////////////////////

`timescale 1ns/1ps

module burst_planner (
  input  logic                         aclk,
  input  logic                         areset,
  input  logic                         ctrl_start,
  input  read_engine_pkg::read_req_t   ctrl_req,
  input  logic                         ctrl_done,
  output logic                         ctrl_busy,
  output logic                         plan_load,
  output read_engine_pkg::burst_plan_t plan
);

  logic                                          busy_q;
  logic                                          accept;
  logic [read_engine_pkg::BURST_CNT_WIDTH-1:0]   full_bursts;
  logic [read_engine_pkg::LOG_BURST_LEN-1:0]     tail_beats;
  logic [axi_read_pkg::AXI_LEN_WIDTH-1:0]        tail_len;
  logic                                          has_tail;

  // busy reads low already in the cycle of the done pulse
  assign ctrl_busy = busy_q & ~ctrl_done;
  assign accept    = ctrl_start & ~ctrl_busy;

  // upper bits count full bursts, the low bits are the beats of a short tail
  assign full_bursts = ctrl_req.length[read_engine_pkg::LENGTH_WIDTH-1:
                                       read_engine_pkg::LOG_BURST_LEN];
  assign tail_beats  = ctrl_req.length[read_engine_pkg::LOG_BURST_LEN-1:0];
  assign has_tail    = (tail_beats != '0);
  assign tail_len    = {{(axi_read_pkg::AXI_LEN_WIDTH - read_engine_pkg::LOG_BURST_LEN){1'b0}},
                        tail_beats};

  always_ff @(posedge aclk) begin
    if (areset) begin
      busy_q    <= 1'b0;
      plan_load <= 1'b0;
    end else begin
      plan_load <= accept;
      // a start in the done cycle wins over the clear
      if (accept) begin
        busy_q <= 1'b1;
      end else if (ctrl_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // plan registers are only read after plan_load, so they carry no reset
  always_ff @(posedge aclk) begin
    if (accept) begin
      plan.offset           <= ctrl_req.offset;
      plan.bursts_minus_one <= has_tail ? full_bursts : full_bursts - 1;
      plan.final_len        <= has_tail ? tail_len - 1 : read_engine_pkg::FULL_LEN;
    end
  end

endmodule

/* hdl/read_engine_pkg.sv */
////////////////////////////////////////
// engine sizing, request and burst-plan types of the burst read engine
// compile after the AXI read package, whose widths it uses
////////////////////////////////////////

package read_engine_pkg;

  ////////////////////////////////////////
  // burst and FIFO sizing
  ////////////////////////////////////////

  // beats in one full burst, 16 for 64 bytes of 4-byte beats
  localparam int unsigned BURST_LEN = axi_read_pkg::BURST_BYTES / axi_read_pkg::BEAT_BYTES;
  localparam int unsigned LOG_BURST_LEN = $clog2(BURST_LEN);

  // the most bursts that may be issued and not yet returned
  localparam int unsigned MAX_OUTSTANDING = 3;
  localparam int unsigned CREDIT_WIDTH = $clog2(MAX_OUTSTANDING + 1);

  localparam int unsigned LENGTH_WIDTH = 16;
  localparam int unsigned BURST_CNT_WIDTH = LENGTH_WIDTH - LOG_BURST_LEN;

  // room for every issued burst plus the words still below the stall level
  localparam int unsigned FIFO_DEPTH = BURST_LEN * (MAX_OUTSTANDING + 1);
  localparam int unsigned FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam logic [FIFO_ADDR_WIDTH:0] FIFO_STALL_LEVEL = (FIFO_ADDR_WIDTH + 1)'(BURST_LEN);

  // arlen code of a full burst
  localparam logic [axi_read_pkg::AXI_LEN_WIDTH-1:0] FULL_LEN =
    (axi_read_pkg::AXI_LEN_WIDTH)'(BURST_LEN - 1);

  ////////////////////////////////////////
  // request, plan and address-channel state
  ////////////////////////////////////////

  typedef struct packed {
    logic [axi_read_pkg::AXI_ADDR_WIDTH-1:0] offset;
    logic [LENGTH_WIDTH-1:0]                 length;
  } read_req_t;

  // final_len is arlen-coded, so a 16-beat tail reads as 15
  typedef struct packed {
    logic [BURST_CNT_WIDTH-1:0]              bursts_minus_one;
    logic [axi_read_pkg::AXI_LEN_WIDTH-1:0]  final_len;
    logic [axi_read_pkg::AXI_ADDR_WIDTH-1:0] offset;
  } burst_plan_t;

  typedef enum logic [1:0] {
    ar_idle,
    ar_wait,
    ar_valid
  } ar_state_t;

endpackage

/* hdl/axi_read_pkg.sv */
////////////////////////////////////////
// AXI4 read channel and output stream definitions for the read engine
// this package depends on nothing else, so compile it first
////////////////////////////////////////

package axi_read_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  localparam int unsigned AXI_ADDR_WIDTH = 32;
  localparam int unsigned AXI_DATA_WIDTH = 32;
  localparam int unsigned AXI_LEN_WIDTH = 8;

  // bytes carried by one beat on the data channel
  localparam int unsigned BEAT_BYTES = AXI_DATA_WIDTH / 8;

  // arsize code for full-width beats, 3'b010 for 4 bytes
  localparam logic [2:0] AXI_SIZE = 3'($clog2(BEAT_BYTES));

  // address step between two full bursts
  // the engine derives its burst length in beats from this value
  localparam logic [AXI_ADDR_WIDTH-1:0] BURST_BYTES = 64;

  ////////////////////////////////////////
  // channel payloads
  ////////////////////////////////////////

  typedef logic [AXI_DATA_WIDTH-1:0] data_t;

  // read-address request, len is the AXI beat count minus one
  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_LEN_WIDTH-1:0]  len;
    logic [2:0]                size;
  } ar_req_t;

  // one beat on the read-data channel, rresp is not carried
  typedef struct packed {
    data_t data;
    logic  last;
  } r_beat_t;

endpackage
